//--- decode_queue.sv
`timescale 1ns/1ps

module decode_queue
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        push_valid,
    output logic        push_ready,
    input  logic [31:0] push_pc,
    input  logic [4:0]  push_rs,
    input  logic [4:0]  push_rt,
    input  logic        push_read_rs,
    input  logic        push_read_rt,
    input  logic [4:0]  push_dst,
    input  logic        push_write_dst,

    output logic        pop_valid,
    input  logic        pop_ready,
    output logic [31:0] pop_pc,
    output logic [4:0]  pop_rs,
    output logic [4:0]  pop_rt,
    output logic        pop_read_rs,
    output logic        pop_read_rt,
    output logic [4:0]  pop_dst,
    output logic        pop_write_dst
);

    logic [31:0] pc_mem       [QUEUE_DEPTH];
    logic [4:0]  rs_mem       [QUEUE_DEPTH];
    logic [4:0]  rt_mem       [QUEUE_DEPTH];
    logic [4:0]  dst_mem      [QUEUE_DEPTH];
    logic        read_rs_mem  [QUEUE_DEPTH];
    logic        read_rt_mem  [QUEUE_DEPTH];
    logic        write_mem    [QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              full;
    logic              push_fire;
    logic              pop_fire;

    assign full       = (count == QCNT_W'(QUEUE_DEPTH));
    assign pop_valid  = (count != '0);
    // room frees up when the head leaves this cycle
    assign push_ready = !full || pop_ready;
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    assign pop_pc        = pc_mem[rd_ptr];
    assign pop_rs        = rs_mem[rd_ptr];
    assign pop_rt        = rt_mem[rd_ptr];
    assign pop_read_rs   = read_rs_mem[rd_ptr];
    assign pop_read_rt   = read_rt_mem[rd_ptr];
    assign pop_dst       = dst_mem[rd_ptr];
    assign pop_write_dst = write_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_fire) begin
            pc_mem[wr_ptr]      <= push_pc;
            rs_mem[wr_ptr]      <= push_rs;
            rt_mem[wr_ptr]      <= push_rt;
            read_rs_mem[wr_ptr] <= push_read_rs;
            read_rt_mem[wr_ptr] <= push_read_rt;
            dst_mem[wr_ptr]     <= push_dst;
            write_mem[wr_ptr]   <= push_write_dst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a push into a full queue swaps with a pop and keeps both pointers equal
    a_full_push: assert property (@(posedge clk) disable iff (!rst_n)
        (full && push_fire) |-> pop_fire ##1 (full && (wr_ptr == rd_ptr)));

endmodule

//--- fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,

    output logic        push_valid,
    input  logic        push_ready,
    output logic [31:0] push_pc,
    output logic [4:0]  push_rs,
    output logic [4:0]  push_rt,
    output logic        push_read_rs,
    output logic        push_read_rt,
    output logic [4:0]  push_dst,
    output logic        push_write_dst
);

    logic [31:0] pc;
    logic        slot_pending;
    logic [31:0] jump_target_q;
    logic [31:0] slot_addr;
    logic        is_jump;
    logic        push_fire;
    logic        writes_gpr;
    instr_word_u instr;

    assign instr     = imem_data;
    assign imem_addr = pc;
    assign push_pc   = pc;
    assign push_fire = push_valid && push_ready;
    assign slot_addr = pc + 32'd4;

    // J inside a delay slot is not followed
    assign is_jump = (instr.j.opcode == OPC_J) && !slot_pending;

    always_comb begin
        push_rs      = instr.r.rs;
        push_rt      = instr.r.rt;
        push_read_rs = 1'b0;
        push_read_rt = 1'b0;
        push_dst     = 5'd0;
        writes_gpr   = 1'b0;
        case (instr.r.opcode)
            OPC_SPECIAL: begin
                push_read_rs = 1'b1;
                push_read_rt = 1'b1;
                push_dst     = instr.r.rd;
                writes_gpr   = 1'b1;
            end
            OPC_ADDIU, OPC_ORI, OPC_LW: begin
                push_rs      = instr.i.rs;
                push_read_rs = 1'b1;
                push_dst     = instr.i.rt;
                writes_gpr   = 1'b1;
            end
            OPC_SW: begin
                push_read_rs = 1'b1;
                push_read_rt = 1'b1;
            end
            // J only steers fetch, like any unknown opcode
            default: begin
                writes_gpr = 1'b0;
            end
        endcase
    end

    // $0 never gets a destination
    assign push_write_dst = writes_gpr && (push_dst != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= RESET_PC;
            slot_pending <= 1'b0;
            push_valid   <= 1'b0;
        end else begin
            push_valid <= 1'b1;
            if (push_fire) begin
                if (slot_pending) begin
                    pc <= jump_target_q;
                end else begin
                    pc <= slot_addr;
                end
                slot_pending <= is_jump;
            end
        end
    end

    // target taken from the delay-slot address region
    always_ff @(posedge clk) begin
        if (push_fire && is_jump) begin
            jump_target_q <= {slot_addr[31:28], instr.j.target, 2'b00};
        end
    end

endmodule

//--- issue_checker.sv
`timescale 1ns/1ps

module issue_checker
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  logic            issue_ready,
    input  logic [31:0]     issue_pc,
    input  logic [ID_W-1:0] issue_id,
    input  logic [PR_W-1:0] issue_phy_rs,
    input  logic [PR_W-1:0] issue_phy_rt,
    input  logic [PR_W-1:0] issue_phy_dst,
    input  logic            issue_has_dst,
    input  logic            pr_release_valid,
    input  logic [PR_W-1:0] pr_release_pr,
    output logic [31:0]     ref_addr,
    input  logic [31:0]     ref_data,
    output logic            stale_valid,
    output logic [PR_W-1:0] stale_pr,
    output int              mismatches,
    output int              accepted,
    output int              allocs
);

    logic [PR_W-1:0]         map [NUM_ARCH_REGS];
    logic [NUM_PHY_REGS-1:0] busy;
    logic [31:0]             model_pc;
    logic [31:0]             model_target;
    logic                    model_slot;
    logic [ID_W-1:0]         exp_id;
    logic                    was_held;
    int                      cycle;
    int                      last_release;
    int                      load_cycle;

    // expected renamed sources and logical destination of one word
    function automatic void expected_fields(input logic [31:0] word,
                                            output logic [PR_W-1:0] rs_pr,
                                            output logic [PR_W-1:0] rt_pr,
                                            output logic [4:0] dst,
                                            output logic writes);
        logic [5:0] opc;
        logic       rd_rs;
        logic       rd_rt;
        opc   = word[31:26];
        rd_rs = 1'b0;
        rd_rt = 1'b0;
        dst   = 5'd0;
        if (opc == OPC_SPECIAL) begin
            rd_rs = 1'b1;
            rd_rt = 1'b1;
            dst   = word[15:11];
        end else if (opc == OPC_ADDIU || opc == OPC_ORI || opc == OPC_LW) begin
            rd_rs = 1'b1;
            dst   = word[20:16];
        end else if (opc == OPC_SW) begin
            rd_rs = 1'b1;
            rd_rt = 1'b1;
        end
        writes = (dst != 5'd0);
        rs_pr  = rd_rs ? map[word[25:21]] : '0;
        rt_pr  = rd_rt ? map[word[20:16]] : '0;
    endfunction

    function automatic logic [PR_W-1:0] lowest_free();
        logic [PR_W-1:0] pr;
        logic            found;
        pr    = '0;
        found = 1'b0;
        for (int i = FIRST_FREE_PR; i < NUM_PHY_REGS; i++) begin
            if (!busy[i] && !found) begin
                pr    = PR_W'(i);
                found = 1'b1;
            end
        end
        return pr;
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        mismatches++;
        $display("mismatch %s expected 0x%0h actual 0x%0h", name, exp, act);
    endtask

    always @(posedge clk or negedge rst_n) begin : compare
        logic [PR_W-1:0] e_rs;
        logic [PR_W-1:0] e_rt;
        logic [PR_W-1:0] e_free;
        logic [4:0]      e_dst;
        logic            e_wr;
        logic [31:0]     next_pc;
        if (!rst_n) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] = PR_W'(i);
            end
            busy = '0;
            for (int i = 0; i < FIRST_FREE_PR; i++) begin
                busy[i] = 1'b1;
            end
            model_pc     = RESET_PC;
            model_target = '0;
            model_slot   = 1'b0;
            exp_id       = '0;
            was_held     = 1'b0;
            cycle        = 0;
            last_release = -1;
            load_cycle   = 0;
            ref_addr     = RESET_PC;
            stale_valid  = 1'b0;
            stale_pr     = '0;
            mismatches   = 0;
            accepted     = 0;
            allocs       = 0;
        end else begin
            cycle++;
            stale_valid = 1'b0;
            // a packet not held from the last edge was loaded there
            if (issue_valid && !was_held) begin
                load_cycle = cycle - 1;
            end
            if (issue_valid && issue_ready) begin
                accepted++;
                expected_fields(ref_data, e_rs, e_rt, e_dst, e_wr);
                if (issue_pc != model_pc) note_mismatch("pc", model_pc, issue_pc);
                if (issue_id != exp_id) note_mismatch("id", 32'(exp_id), 32'(issue_id));
                if (issue_phy_rs != e_rs) note_mismatch("phy_rs", 32'(e_rs), 32'(issue_phy_rs));
                if (issue_phy_rt != e_rt) note_mismatch("phy_rt", 32'(e_rt), 32'(issue_phy_rt));
                if (issue_has_dst != e_wr) begin
                    note_mismatch("has_dst", 32'(e_wr), 32'(issue_has_dst));
                end
                if (e_wr && issue_has_dst) begin
                    e_free = lowest_free();
                    // exact only if no release landed after the load edge
                    if (last_release < load_cycle) begin
                        if (issue_phy_dst != e_free) begin
                            note_mismatch("alloc", 32'(e_free), 32'(issue_phy_dst));
                        end
                    end else if (issue_phy_dst < PR_W'(FIRST_FREE_PR) || busy[issue_phy_dst]) begin
                        note_mismatch("alloc_free", 32'(e_free), 32'(issue_phy_dst));
                    end
                    allocs++;
                    if (map[e_dst] >= PR_W'(FIRST_FREE_PR)) begin
                        stale_valid = 1'b1;
                        stale_pr    = map[e_dst];
                    end
                    busy[issue_phy_dst] = 1'b1;
                    map[e_dst]          = issue_phy_dst;
                end
                // J then its delay slot, then the target
                if (model_slot) begin
                    next_pc    = model_target;
                    model_slot = 1'b0;
                end else begin
                    next_pc = model_pc + 32'd4;
                    if (ref_data[31:26] == OPC_J) begin
                        model_slot   = 1'b1;
                        model_target = {next_pc[31:28], ref_data[25:0], 2'b00};
                    end
                end
                model_pc = next_pc;
                ref_addr = next_pc;
                exp_id   = exp_id + 1'b1;
            end
            if (pr_release_valid) begin
                busy[pr_release_pr] = 1'b0;
                last_release        = cycle;
            end
            was_held = issue_valid && !issue_ready;
        end
    end

endmodule

//--- issue_core.f
issue_pkg.sv
fetch_decode.sv
decode_queue.sv
rename_issue.sv
issue_core.sv
issue_checker.sv
tb_issue_core.sv

//--- issue_core.sv
`timescale 1ns/1ps

module issue_core
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    output logic [31:0]     imem_addr,
    input  logic [31:0]     imem_data,

    output logic            issue_valid,
    input  logic            issue_ready,
    output logic [31:0]     issue_pc,
    output logic [ID_W-1:0] issue_id,
    output logic [PR_W-1:0] issue_phy_rs,
    output logic [PR_W-1:0] issue_phy_rt,
    output logic [PR_W-1:0] issue_phy_dst,
    output logic            issue_has_dst,

    input  logic            pr_release_valid,
    input  logic [PR_W-1:0] pr_release_pr
);

    // fetch to queue
    logic        push_valid;
    logic        push_ready;
    logic [31:0] push_pc;
    logic [4:0]  push_rs;
    logic [4:0]  push_rt;
    logic        push_read_rs;
    logic        push_read_rt;
    logic [4:0]  push_dst;
    logic        push_write_dst;

    // queue to rename
    logic        pop_valid;
    logic        pop_ready;
    logic [31:0] pop_pc;
    logic [4:0]  pop_rs;
    logic [4:0]  pop_rt;
    logic        pop_read_rs;
    logic        pop_read_rt;
    logic [4:0]  pop_dst;
    logic        pop_write_dst;

    fetch_decode fetch_decode_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .push_valid     (push_valid),
        .push_ready     (push_ready),
        .push_pc        (push_pc),
        .push_rs        (push_rs),
        .push_rt        (push_rt),
        .push_read_rs   (push_read_rs),
        .push_read_rt   (push_read_rt),
        .push_dst       (push_dst),
        .push_write_dst (push_write_dst)
    );

    decode_queue decode_queue_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .push_valid     (push_valid),
        .push_ready     (push_ready),
        .push_pc        (push_pc),
        .push_rs        (push_rs),
        .push_rt        (push_rt),
        .push_read_rs   (push_read_rs),
        .push_read_rt   (push_read_rt),
        .push_dst       (push_dst),
        .push_write_dst (push_write_dst),
        .pop_valid      (pop_valid),
        .pop_ready      (pop_ready),
        .pop_pc         (pop_pc),
        .pop_rs         (pop_rs),
        .pop_rt         (pop_rt),
        .pop_read_rs    (pop_read_rs),
        .pop_read_rt    (pop_read_rt),
        .pop_dst        (pop_dst),
        .pop_write_dst  (pop_write_dst)
    );

    rename_issue rename_issue_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .pop_valid        (pop_valid),
        .pop_ready        (pop_ready),
        .pop_pc           (pop_pc),
        .pop_rs           (pop_rs),
        .pop_rt           (pop_rt),
        .pop_read_rs      (pop_read_rs),
        .pop_read_rt      (pop_read_rt),
        .pop_dst          (pop_dst),
        .pop_write_dst    (pop_write_dst),
        .issue_valid      (issue_valid),
        .issue_ready      (issue_ready),
        .issue_pc         (issue_pc),
        .issue_id         (issue_id),
        .issue_phy_rs     (issue_phy_rs),
        .issue_phy_rt     (issue_phy_rt),
        .issue_phy_dst    (issue_phy_dst),
        .issue_has_dst    (issue_has_dst),
        .pr_release_valid (pr_release_valid),
        .pr_release_pr    (pr_release_pr)
    );

endmodule

//--- issue_pkg.sv
package issue_pkg;

    // register file sizes
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHY_REGS  = 48;
    localparam int FIRST_FREE_PR = 32;
    localparam int PR_W          = 6;

    // issue sequence number, wraps
    localparam int ID_W = 8;

    localparam logic [31:0] RESET_PC = 32'h0000_3000;

    // decoded-instruction FIFO
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // one fetched word, three ways to look at it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_word_u;

endpackage

//--- rename_issue.sv
`timescale 1ns/1ps

module rename_issue
    import issue_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            pop_valid,
    output logic            pop_ready,
    input  logic [31:0]     pop_pc,
    input  logic [4:0]      pop_rs,
    input  logic [4:0]      pop_rt,
    input  logic            pop_read_rs,
    input  logic            pop_read_rt,
    input  logic [4:0]      pop_dst,
    input  logic            pop_write_dst,

    output logic            issue_valid,
    input  logic            issue_ready,
    output logic [31:0]     issue_pc,
    output logic [ID_W-1:0] issue_id,
    output logic [PR_W-1:0] issue_phy_rs,
    output logic [PR_W-1:0] issue_phy_rt,
    output logic [PR_W-1:0] issue_phy_dst,
    output logic            issue_has_dst,

    input  logic            pr_release_valid,
    input  logic [PR_W-1:0] pr_release_pr
);

    // $0 is not held, it always reads as PR0
    logic [PR_W-1:0]         rat [1:NUM_ARCH_REGS-1];
    logic [NUM_PHY_REGS-1:0] used;
    logic [ID_W-1:0]         seq;

    logic                    free_found;
    logic [PR_W-1:0]         free_pr;
    logic                    out_free;
    logic                    load;
    logic [PR_W-1:0]         src_rs;
    logic [PR_W-1:0]         src_rt;

    // lowest free register, scanning down so the last hit wins
    always_comb begin
        free_found = 1'b0;
        free_pr    = '0;
        for (int i = NUM_PHY_REGS - 1; i >= FIRST_FREE_PR; i--) begin
            if (!used[i]) begin
                free_found = 1'b1;
                free_pr    = PR_W'(i);
            end
        end
    end

    always_comb begin
        src_rs = '0;
        src_rt = '0;
        if (pop_read_rs && (pop_rs != 5'd0)) begin
            src_rs = rat[pop_rs];
        end
        if (pop_read_rt && (pop_rt != 5'd0)) begin
            src_rt = rat[pop_rt];
        end
    end

    assign out_free  = !issue_valid || issue_ready;
    // no free register holds the head in the queue
    assign pop_ready = out_free && (!pop_write_dst || free_found);
    assign load      = pop_valid && pop_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_ARCH_REGS; i++) begin
                rat[i] <= PR_W'(i);
            end
            used <= '0;
            for (int i = 0; i < FIRST_FREE_PR; i++) begin
                used[i] <= 1'b1;
            end
            seq         <= '0;
            issue_valid <= 1'b0;
        end else begin
            // release first, so the same edge cannot reuse it
            if (pr_release_valid) begin
                used[pr_release_pr] <= 1'b0;
            end
            if (load) begin
                seq         <= seq + 1'b1;
                issue_valid <= 1'b1;
                if (pop_write_dst) begin
                    used[free_pr] <= 1'b1;
                    rat[pop_dst]  <= free_pr;
                end
            end else if (issue_ready) begin
                issue_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            issue_pc      <= pop_pc;
            issue_id      <= seq;
            issue_phy_rs  <= src_rs;
            issue_phy_rt  <= src_rt;
            issue_phy_dst <= pop_write_dst ? free_pr : '0;
            issue_has_dst <= pop_write_dst;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && !issue_ready) |=> issue_valid && $stable(issue_pc)
            && $stable(issue_id) && $stable(issue_phy_rs) && $stable(issue_phy_rt)
            && $stable(issue_phy_dst) && $stable(issue_has_dst));

    // the architectural registers 0..31 are never handed out again
    a_dst_range: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && issue_has_dst) |-> (issue_phy_dst >= PR_W'(FIRST_FREE_PR)));

endmodule

//--- run.sh
#!/bin/bash
# build and run the issue_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_issue_core -f issue_core.f \
    > build.log 2>&1 && ./obj_dir/Vtb_issue_core > sim.log 2>&1 || { cat build.log; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- tb_issue_core.sv
`timescale 1ns/1ps

module tb_issue_core
    import issue_pkg::*;
;

    localparam int PROG_LEN = 31;

    logic            clk;
    logic            rst_n;
    logic [31:0]     imem_addr;
    logic [31:0]     imem_data;
    logic            issue_valid;
    logic            issue_ready;
    logic [31:0]     issue_pc;
    logic [ID_W-1:0] issue_id;
    logic [PR_W-1:0] issue_phy_rs;
    logic [PR_W-1:0] issue_phy_rt;
    logic [PR_W-1:0] issue_phy_dst;
    logic            issue_has_dst;
    logic            pr_release_valid;
    logic [PR_W-1:0] pr_release_pr;

    logic [31:0]     ref_addr;
    logic [31:0]     ref_data;
    logic            stale_valid;
    logic [PR_W-1:0] stale_pr;
    int              mismatches;
    int              accepted;
    int              allocs;

    logic [31:0]     prog [PROG_LEN];
    logic [PR_W-1:0] stale_q [$];
    int              other_errors;

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd);
        // addu
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, 6'h21};
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        if (addr >= RESET_PC && off < 32'(4 * PROG_LEN) && addr[1:0] == 2'b00) begin
            return prog[off[6:2]];
        end
        // unused opcode, inverted address folded into the low bits
        return {6'h3f, ~addr[25:0] ^ {20'd0, addr[31:26]}};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign imem_data = mem_read(imem_addr);
    assign ref_data  = mem_read(ref_addr);

    issue_core issue_core_inst (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_pc(issue_pc),
        .issue_id(issue_id), .issue_phy_rs(issue_phy_rs), .issue_phy_rt(issue_phy_rt),
        .issue_phy_dst(issue_phy_dst), .issue_has_dst(issue_has_dst),
        .pr_release_valid(pr_release_valid), .pr_release_pr(pr_release_pr)
    );

    issue_checker issue_checker_inst (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .issue_pc(issue_pc), .issue_id(issue_id), .issue_phy_rs(issue_phy_rs),
        .issue_phy_rt(issue_phy_rt), .issue_phy_dst(issue_phy_dst),
        .issue_has_dst(issue_has_dst), .pr_release_valid(pr_release_valid),
        .pr_release_pr(pr_release_pr), .ref_addr(ref_addr), .ref_data(ref_data),
        .stale_valid(stale_valid), .stale_pr(stale_pr), .mismatches(mismatches),
        .accepted(accepted), .allocs(allocs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // registers overwritten in an accepted packet may be handed back
    always @(negedge clk) begin
        if (stale_valid) stale_q.push_back(stale_pr);
    end

    initial begin
        prog[0]  = enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'd1);
        prog[1]  = enc_i(OPC_ORI, 5'd1, 5'd2, 16'd5);
        prog[2]  = enc_r(5'd1, 5'd2, 5'd3);
        prog[3]  = enc_r(5'd3, 5'd3, 5'd0);
        prog[4]  = enc_i(OPC_SW, 5'd2, 5'd3, 16'd8);
        prog[5]  = {OPC_J, 26'(32'h0000_3028 >> 2)};
        prog[6]  = enc_i(OPC_ADDIU, 5'd3, 5'd4, 16'd2);
        // skipped by the jump
        prog[7]  = enc_i(OPC_ADDIU, 5'd31, 5'd31, 16'd7);
        prog[8]  = enc_i(OPC_ADDIU, 5'd31, 5'd31, 16'd8);
        prog[9]  = enc_i(OPC_ADDIU, 5'd31, 5'd31, 16'd9);
        prog[10] = enc_i(OPC_LW, 5'd4, 5'd5, 16'd4);
        prog[11] = enc_i(OPC_ADDIU, 5'd1, 5'd1, 16'd1);
        prog[12] = enc_i(OPC_ADDIU, 5'd1, 5'd2, 16'd1);
        prog[13] = enc_r(5'd1, 5'd2, 5'd3);
        prog[14] = enc_i(OPC_ADDIU, 5'd3, 5'd1, 16'd1);
        prog[15] = enc_i(OPC_ADDIU, 5'd1, 5'd2, 16'd1);
        prog[16] = enc_i(OPC_ADDIU, 5'd2, 5'd3, 16'd1);
        prog[17] = enc_i(OPC_ADDIU, 5'd3, 5'd4, 16'd1);
        prog[18] = enc_i(OPC_ADDIU, 5'd4, 5'd5, 16'd1);
        prog[19] = enc_i(OPC_ADDIU, 5'd5, 5'd1, 16'd1);
        prog[20] = enc_i(OPC_ADDIU, 5'd1, 5'd2, 16'd1);
        prog[21] = enc_i(OPC_ADDIU, 5'd2, 5'd3, 16'd1);
        prog[22] = enc_i(OPC_ADDIU, 5'd1, 5'd6, 16'd3);
        prog[23] = enc_r(5'd6, 5'd2, 5'd7);
        prog[24] = enc_i(OPC_SW, 5'd7, 5'd6, 16'd0);
        prog[25] = enc_i(OPC_LW, 5'd7, 5'd6, 16'd0);
        prog[26] = enc_i(OPC_ORI, 5'd6, 5'd0, 16'hff);
        prog[27] = enc_i(OPC_ADDIU, 5'd6, 5'd1, 16'd1);
        prog[28] = enc_r(5'd1, 5'd6, 5'd2);
        prog[29] = enc_i(OPC_ADDIU, 5'd2, 5'd3, 16'd1);
        prog[30] = enc_i(OPC_LW, 5'd3, 5'd4, 16'd0);
    end

    task automatic end_run();
        $display("closing: mismatch errors %0d, other errors %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin : stimulus
        logic [31:0] rng;
        logic [31:0] hold_addr;
        logic        timed_out;
        int          n;
        int          acc0;
        rst_n            = 1'b0;
        issue_ready      = 1'b0;
        pr_release_valid = 1'b0;
        pr_release_pr    = '0;
        other_errors     = 0;
        timed_out        = 1'b0;
        rng              = 32'd77515;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (issue_valid || imem_addr != RESET_PC) begin
                $display("error: outputs not at reset values during reset");
                other_errors++;
            end
        end
        rst_n = 1'b1;
        @(negedge clk);
        if (issue_valid || imem_addr != RESET_PC) begin
            $display("error: outputs not at reset values right after reset");
            other_errors++;
        end
        issue_ready = 1'b1;

        // no releases until all 16 free registers are taken
        n = 0;
        while (allocs < 16 && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (allocs < 16) begin
            $display("error: timed out waiting for 16 allocations");
            other_errors++;
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            acc0 = accepted;
            repeat (8) @(negedge clk);
            hold_addr = imem_addr;
            repeat (12) @(negedge clk);
            if (accepted != acc0) begin
                $display("error: issue went on with no free physical register");
                other_errors++;
            end
            if (imem_addr != hold_addr) begin
                $display("error: fetch moved on while the queue should be full");
                other_errors++;
            end
            pr_release_valid = 1'b1;
            pr_release_pr    = stale_q.pop_front();
            @(negedge clk);
            pr_release_valid = 1'b0;
            n = 0;
            while (accepted == acc0 && n < 100) begin
                @(negedge clk);
                n++;
            end
            if (accepted == acc0) begin
                $display("error: timed out waiting for issue to resume after a release");
                other_errors++;
                timed_out = 1'b1;
            end
        end

        if (!timed_out) begin
            acc0 = accepted;
            n    = 0;
            while (accepted < acc0 + 150 && n < 4000) begin
                @(negedge clk);
                rng              = xorshift(rng);
                issue_ready      = rng[0] | rng[1];
                pr_release_valid = 1'b0;
                if (stale_q.size() > 0 && rng[4:2] == 3'd0) begin
                    pr_release_valid = 1'b1;
                    pr_release_pr    = stale_q.pop_front();
                end
                n++;
            end
            if (accepted < acc0 + 150) begin
                $display("error: timed out in the random back-pressure run");
                other_errors++;
            end
            @(negedge clk);
            pr_release_valid = 1'b0;
            issue_ready      = 1'b1;
        end
        end_run();
    end

endmodule
